/* common/gpio_pkg.sv */
/*
  shared definitions for the gpio peripheral
    - apb address and data widths
    - register offset type and register map
    - register reset values
    - input synchronizer depth
*/

package gpio_pkg;

   // ------------------------------
   // bus widths
   // ------------------------------
   localparam int apb_addr_width = 6;   // byte address, 16 words of space
   localparam int apb_data_width = 32;

   typedef logic [apb_addr_width-1:0] reg_offset_t;

   // ------------------------------
   // register map
   // ------------------------------
   localparam reg_offset_t off_dir        = 6'h00; // 1 = pin drives out
   localparam reg_offset_t off_out        = 6'h04; // output value
   localparam reg_offset_t off_in         = 6'h08; // synced pin state, read only
   localparam reg_offset_t off_int_en     = 6'h0C; // per pin change irq enable
   localparam reg_offset_t off_int_status = 6'h10; // sticky, write 1 to clear

   // reset values, sliced down to the pin count by users
   localparam logic [apb_data_width-1:0] dir_reset        = 32'h0000_0000;
   localparam logic [apb_data_width-1:0] out_reset        = 32'h0000_0000;
   localparam logic [apb_data_width-1:0] int_en_reset     = 32'h0000_0000;
   localparam logic [apb_data_width-1:0] int_status_reset = 32'h0000_0000;

   // flops between the pad and the in register
   localparam int sync_stages = 2;

endpackage

/* common/gpio_reg_if.sv */
/*
  register access bus between the apb front end and the register bank
    - single cycle read and write strobes
    - byte offset, write data, registered read data
*/

interface gpio_reg_if #(
   parameter int gpio_width = 16
);

   logic                        read;  // setup phase pulse
   logic                        write; // access phase pulse
   logic [gpio_pkg::apb_addr_width-1:0] addr;
   logic [gpio_width-1:0]       wdata;
   logic [gpio_width-1:0]       rdata; // valid in access phase

   // bus side, the apb decoder
   modport ctrl (output read, write, addr, wdata, input rdata);

   // register bank side
   modport regs (input read, write, addr, wdata, output rdata);

endinterface

/* gpio_subunit/gpio_change_detect.sv */
/*
  gpio input path
    - sync_stages deep synchronizer per pin
    - previous value register and change detect
    - sticky interrupt status with write 1 to clear
*/

module gpio_change_detect #(
   parameter int gpio_width = 16
) (
   input  logic                  pclk,
   input  logic                  rst,
   input  logic [gpio_width-1:0] pin_in,   // async pad inputs
   input  logic [gpio_width-1:0] int_en,
   input  logic [gpio_width-1:0] clear,    // w1c mask, one cycle
   output logic [gpio_width-1:0] pin_sync, // feeds the in register
   output logic [gpio_width-1:0] status
);

   // stage 0 samples the pads
   logic [gpio_pkg::sync_stages-1:0][gpio_width-1:0] sync_q;

   logic [gpio_width-1:0] prev_q;  // last synced value
   logic [gpio_width-1:0] change;  // either edge
   logic [gpio_width-1:0] status_q;

   // ------------------------------
   // synchronizer
   // ------------------------------
   always_ff @(posedge pclk)
   begin
      if (rst)
      begin
         sync_q <= '0;
         prev_q <= '0;
      end
      else
      begin
         sync_q[0] <= pin_in;
         for (int i = 1; i < gpio_pkg::sync_stages; i++)
         begin
            sync_q[i] <= sync_q[i-1];
         end
         prev_q <= pin_sync;
      end
   end

   assign pin_sync = sync_q[gpio_pkg::sync_stages-1];
   assign change   = pin_sync ^ prev_q;

   // ------------------------------
   // sticky status
   // ------------------------------
   always_ff @(posedge pclk)
   begin
      if (rst)
         status_q <= gpio_pkg::int_status_reset[gpio_width-1:0];
      else // new change beats a same cycle clear
         status_q <= (status_q & ~clear) | (change & int_en);
   end

   assign status = status_q;

endmodule

/* gpio_subunit/gpio_subunit.sv */
/*
  gpio register bank
    - offset decode against the package register map
    - direction, output and interrupt enable registers
    - read back mux, registered on the read strobe
    - write 1 to clear mask for the status register
    - pin drive and output enable with test override
    - input synchronizer and change detect instance
*/

module gpio_subunit #(
   parameter int gpio_width = 16
) (
   input  logic                  pclk,
   input  logic                  rst,
   gpio_reg_if.regs              bus,
   input  logic [gpio_width-1:0] pin_in,
   input  logic [gpio_width-1:0] tri_state_enable, // 1 forces pin to hi-z
   output logic [gpio_width-1:0] pin_out,
   output logic [gpio_width-1:0] pin_oe_n,         // active low enable
   output logic [gpio_width-1:0] interrupt         // per pin pending
);

   // address hits
   logic sel_dir;
   logic sel_out;
   logic sel_in;
   logic sel_int_en;
   logic sel_int_status;

   logic [gpio_width-1:0] dir_q;    // 1 = output
   logic [gpio_width-1:0] out_q;
   logic [gpio_width-1:0] int_en_q;
   logic [gpio_width-1:0] rdata_q;

   logic [gpio_width-1:0] rd_word;  // selected read value
   logic [gpio_width-1:0] clear;    // one cycle w1c mask
   logic [gpio_width-1:0] pin_sync;
   logic [gpio_width-1:0] status;

   // ------------------------------
   // decode
   // ------------------------------
   assign sel_dir        = (bus.addr == gpio_pkg::off_dir);
   assign sel_out        = (bus.addr == gpio_pkg::off_out);
   assign sel_in         = (bus.addr == gpio_pkg::off_in);
   assign sel_int_en     = (bus.addr == gpio_pkg::off_int_en);
   assign sel_int_status = (bus.addr == gpio_pkg::off_int_status);

   // ------------------------------
   // register bank
   // ------------------------------
   always_ff @(posedge pclk)
   begin
      if (rst)
      begin
         dir_q    <= gpio_pkg::dir_reset[gpio_width-1:0];
         out_q    <= gpio_pkg::out_reset[gpio_width-1:0];
         int_en_q <= gpio_pkg::int_en_reset[gpio_width-1:0];
      end
      else if (bus.write)
      begin
         if (sel_dir)
            dir_q <= bus.wdata;
         if (sel_out)
            out_q <= bus.wdata;
         if (sel_int_en)
            int_en_q <= bus.wdata;
         // in register is read only, unmapped writes fall through
      end
   end

   // status lives in the change detector, only the mask goes there
   assign clear = (bus.write && sel_int_status) ? bus.wdata : '0;

   // ------------------------------
   // read back
   // ------------------------------
   always_comb
   begin
      rd_word = '0; // unmapped offsets read zero
      if (sel_dir)
         rd_word = dir_q;
      else if (sel_out)
         rd_word = out_q;
      else if (sel_in)
         rd_word = pin_sync;
      else if (sel_int_en)
         rd_word = int_en_q;
      else if (sel_int_status)
         rd_word = status;
   end

   // captured in setup, held through the access phase
   always_ff @(posedge pclk)
   begin
      if (rst)
         rdata_q <= '0;
      else if (bus.read)
         rdata_q <= rd_word;
   end

   assign bus.rdata = rdata_q;

   // ------------------------------
   // pin drive
   // ------------------------------
   assign pin_out   = out_q;
   assign pin_oe_n  = ~(dir_q & ~tri_state_enable); // test input wins
   assign interrupt = status;

   gpio_change_detect #(
      .gpio_width (gpio_width)
   ) i_gpio_change_detect (
      .pclk     (pclk),
      .rst      (rst),
      .pin_in   (pin_in),
      .int_en   (int_en_q),
      .clear    (clear),
      .pin_sync (pin_sync),
      .status   (status)
   );

endmodule

/* hdl/gpio_lite.sv */
/*
  gpio peripheral top level for an apb style bus
    - read and write strobe decode from the apb phases
    - zero padding of read data to the bus width
    - reduction of the per pin interrupts to one line
*/

module gpio_lite #(
   parameter int gpio_width = 16 // at most apb_data_width
) (
   input  logic                                pclk,
   input  logic                                rst,
   // apb slave
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [gpio_pkg::apb_addr_width-1:0] paddr,
   input  logic [gpio_pkg::apb_data_width-1:0] pwdata,
   output logic [gpio_pkg::apb_data_width-1:0] prdata,
   // pins
   input  logic [gpio_width-1:0]               pin_in,
   input  logic [gpio_width-1:0]               tri_state_enable, // test, forces oe off
   output logic [gpio_width-1:0]               pin_out,
   output logic [gpio_width-1:0]               pin_oe_n,
   output logic                                gpio_int
);

   gpio_reg_if #(.gpio_width(gpio_width)) reg_bus ();

   logic [gpio_width-1:0] pin_irq; // one per pin, from the status register

   // ------------------------------
   // apb phase decode
   // ------------------------------
   // read fires in setup so rdata is registered by the access phase
   assign reg_bus.read  = psel & ~penable & ~pwrite;
   assign reg_bus.write = psel &  penable &  pwrite; // access phase only
   assign reg_bus.addr  = paddr;
   assign reg_bus.wdata = pwdata[gpio_width-1:0]; // upper bits dropped

   // zero fill above the pin count
   always_comb
   begin
      prdata                 = '0;
      prdata[gpio_width-1:0] = reg_bus.rdata;
   end

   assign gpio_int = |pin_irq; // any pin pending

   // ------------------------------
   // register bank
   // ------------------------------
   gpio_subunit #(
      .gpio_width (gpio_width)
   ) i_gpio_subunit (
      .pclk             (pclk),
      .rst              (rst),
      .bus              (reg_bus.regs),
      .pin_in           (pin_in),
      .tri_state_enable (tri_state_enable),
      .pin_out          (pin_out),
      .pin_oe_n         (pin_oe_n),
      .interrupt        (pin_irq)
   );

endmodule

/* bench/gpio_tb.sv */
/*
  testbench for the gpio peripheral
    - clock, reset, apb read and write tasks
    - reference register model and expected read function
    - compare tasks for bus words, pin vectors and the irq line
    - pin checker process, register map and interrupt sequences
*/

module gpio_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int gpio_width  = 16;
   localparam int int_timeout = 20; // cycles allowed for an irq edge

   logic                                pclk;
   logic                                rst;
   logic                                psel;
   logic                                penable;
   logic                                pwrite;
   logic [gpio_pkg::apb_addr_width-1:0] paddr;
   logic [gpio_pkg::apb_data_width-1:0] pwdata;
   logic [gpio_pkg::apb_data_width-1:0] prdata;
   logic [gpio_width-1:0]               pin_in;   // also the model of the pads
   logic [gpio_width-1:0]               tri_state_enable;
   logic [gpio_width-1:0]               pin_out;
   logic [gpio_width-1:0]               pin_oe_n;
   logic                                gpio_int;

   // reference copies of the register bank
   logic [gpio_width-1:0] dir_m;
   logic [gpio_width-1:0] out_m;
   logic [gpio_width-1:0] int_en_m;
   logic [gpio_width-1:0] status_m;

   int value_errors;
   int timeout_errors;

   gpio_lite #(
      .gpio_width (gpio_width)
   ) i_dut (
      .pclk             (pclk),
      .rst              (rst),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .pin_in           (pin_in),
      .tri_state_enable (tri_state_enable),
      .pin_out          (pin_out),
      .pin_oe_n         (pin_oe_n),
      .gpio_int         (gpio_int)
   );

   always #50 pclk = ~pclk; // 100 ns period

   // ------------------------------
   // reference model
   // ------------------------------
   function automatic logic [gpio_pkg::apb_data_width-1:0] expected_read(
      input gpio_pkg::reg_offset_t offset);
      logic [gpio_pkg::apb_data_width-1:0] word;
      word = '0; // zero above the pin count and for holes
      case (offset)
         gpio_pkg::off_dir:        word[gpio_width-1:0] = dir_m;
         gpio_pkg::off_out:        word[gpio_width-1:0] = out_m;
         gpio_pkg::off_in:         word[gpio_width-1:0] = pin_in;
         gpio_pkg::off_int_en:     word[gpio_width-1:0] = int_en_m;
         gpio_pkg::off_int_status: word[gpio_width-1:0] = status_m;
         default:                  word = '0;
      endcase
      return word;
   endfunction

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_word(input string name, input logic [gpio_pkg::apb_data_width-1:0] exp,
                             input logic [gpio_pkg::apb_data_width-1:0] act);
      if (act !== exp)
      begin
         $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_pins(input string name, input logic [gpio_width-1:0] exp,
                             input logic [gpio_width-1:0] act);
      if (act !== exp)
      begin
         $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
         value_errors++;
      end
   endtask

   // pins checked mid cycle when model and dut have settled
   always @(negedge pclk)
   begin
      if (!rst)
      begin
         check_pins("pin_out", out_m, pin_out);
         // high wherever the pin is an input or the test input is set
         check_pins("pin_oe_n", ~dir_m | tri_state_enable, pin_oe_n);
      end
   end

   // ------------------------------
   // bus tasks
   // ------------------------------
   task automatic apb_write(input gpio_pkg::reg_offset_t addr,
                            input logic [gpio_pkg::apb_data_width-1:0] data);
      @(posedge pclk);
      #10;
      psel    = 1'b1; // setup
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = addr;
      pwdata  = data;
      @(posedge pclk);
      #10;
      penable = 1'b1; // access
      @(posedge pclk);
      #10;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      case (addr) // in and holes ignore writes
         gpio_pkg::off_dir:        dir_m    = data[gpio_width-1:0];
         gpio_pkg::off_out:        out_m    = data[gpio_width-1:0];
         gpio_pkg::off_int_en:     int_en_m = data[gpio_width-1:0];
         gpio_pkg::off_int_status: status_m = status_m & ~data[gpio_width-1:0];
         default:                  ;
      endcase
   endtask

   task automatic apb_read(input gpio_pkg::reg_offset_t addr,
                           output logic [gpio_pkg::apb_data_width-1:0] data);
      @(posedge pclk);
      #10;
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = addr;
      @(posedge pclk);
      #10;
      penable = 1'b1;
      data    = prdata; // registered at the setup edge
      @(posedge pclk);
      #10;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_and_compare(input gpio_pkg::reg_offset_t addr, input string name);
      logic [gpio_pkg::apb_data_width-1:0] data;
      apb_read(addr, data);
      check_word(name, expected_read(addr), data);
   endtask

   task automatic wait_for_int(input logic level);
      int cycles;
      cycles = 0;
      while (gpio_int !== level && cycles < int_timeout)
      begin
         @(posedge pclk);
         #1;
         cycles++;
      end
      if (gpio_int !== level)
      begin
         $display("timeout: gpio_int did not reach %0b within %0d cycles", level, int_timeout);
         timeout_errors++;
      end
   endtask

   // ------------------------------
   // stimulus
   // ------------------------------
   initial
   begin
      logic [gpio_width-1:0] en;
      logic [gpio_width-1:0] tog;
      logic [gpio_width-1:0] clr;
      void'($urandom(32'h65d6));
      pclk = 1'b0;
      rst  = 1'b1;
      {psel, penable, pwrite} = 3'b000;
      paddr = '0;
      pwdata = '0;
      pin_in = '0;
      tri_state_enable = '0;
      {dir_m, out_m, int_en_m, status_m} = '0;
      value_errors = 0;
      timeout_errors = 0;
      repeat (3) @(posedge pclk);
      #10;
      rst = 1'b0;

      // reset state
      read_and_compare(gpio_pkg::off_dir, "dir");
      read_and_compare(gpio_pkg::off_out, "out");
      read_and_compare(gpio_pkg::off_in, "in");
      read_and_compare(gpio_pkg::off_int_en, "int_en");
      read_and_compare(gpio_pkg::off_int_status, "int_status");
      check_bit("gpio_int", 1'b0, gpio_int);

      // write and read back with random upper pwdata bits
      repeat (4)
      begin
         apb_write(gpio_pkg::off_dir, $urandom());
         apb_write(gpio_pkg::off_out, $urandom());
         apb_write(gpio_pkg::off_int_en, $urandom());
         read_and_compare(gpio_pkg::off_dir, "dir");
         read_and_compare(gpio_pkg::off_out, "out");
         read_and_compare(gpio_pkg::off_int_en, "int_en");
      end

      // test override leaves registers untouched
      repeat (3)
      begin
         @(posedge pclk);
         #10;
         tri_state_enable = $urandom();
         read_and_compare(gpio_pkg::off_dir, "dir");
         read_and_compare(gpio_pkg::off_out, "out");
      end
      @(posedge pclk);
      #10;
      tri_state_enable = '0;

      // input readback with irqs off while pins wander
      apb_write(gpio_pkg::off_int_en, '0);
      repeat (4)
      begin
         @(posedge pclk);
         #10;
         pin_in = $urandom();
         repeat (gpio_pkg::sync_stages + 1) @(posedge pclk);
         read_and_compare(gpio_pkg::off_in, "in");
      end
      apb_write(gpio_pkg::off_in, $urandom());
      read_and_compare(gpio_pkg::off_in, "in");
      read_and_compare(gpio_pkg::off_int_status, "int_status");

      // interrupts on enabled pins
      en = $urandom();
      en[0] = 1'b1;
      en[1] = 1'b0; // kept off for the masked check
      tog = $urandom();
      tog[0] = 1'b1;
      apb_write(gpio_pkg::off_int_en, en);
      @(posedge pclk);
      #10;
      pin_in = pin_in ^ tog;
      wait_for_int(1'b1);
      status_m = status_m | (tog & en);
      read_and_compare(gpio_pkg::off_int_status, "int_status");

      // changes on masked pins only
      tog = $urandom() & ~en;
      tog[1] = 1'b1;
      @(posedge pclk);
      #10;
      pin_in = pin_in ^ tog;
      repeat (gpio_pkg::sync_stages + 2) @(posedge pclk);
      read_and_compare(gpio_pkg::off_int_status, "int_status");

      // partial clear then the rest
      clr = status_m & $urandom();
      clr[0] = 1'b1;
      apb_write(gpio_pkg::off_int_status, clr);
      read_and_compare(gpio_pkg::off_int_status, "int_status");
      check_bit("gpio_int", |status_m, gpio_int);
      apb_write(gpio_pkg::off_int_status, 32'hFFFF_FFFF);
      wait_for_int(1'b0);
      read_and_compare(gpio_pkg::off_int_status, "int_status");

      // holes read zero and swallow writes
      for (int a = 'h14; a <= 'h3C; a += 4)
      begin
         apb_write(gpio_pkg::reg_offset_t'(a), $urandom());
         read_and_compare(gpio_pkg::reg_offset_t'(a), "prdata");
      end
      read_and_compare(gpio_pkg::off_dir, "dir");
      read_and_compare(gpio_pkg::off_out, "out");
      read_and_compare(gpio_pkg::off_int_en, "int_en");
      read_and_compare(gpio_pkg::off_int_status, "int_status");

      $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* list.f */
common/gpio_pkg.sv
common/gpio_reg_if.sv
gpio_subunit/gpio_change_detect.sv
gpio_subunit/gpio_subunit.sv
hdl/gpio_lite.sv
bench/gpio_tb.sv

/* Bender.yml */
package:
  name: gpio_lite

sources:
  # shared package and register bus interface
  - common/gpio_pkg.sv
  - common/gpio_reg_if.sv

  # register bank and input path
  - gpio_subunit/gpio_change_detect.sv
  - gpio_subunit/gpio_subunit.sv

  # top level
  - hdl/gpio_lite.sv

  # testbench
  - target: simulation
    files:
      - bench/gpio_tb.sv
